//--- procyon_core.f
rtl/procyon_pkg.sv
rtl/exec_if.sv
rtl/retire_if.sv
rtl/core_control.sv
rtl/fetch_unit.sv
rtl/insn_decoder.sv
rtl/register_file.sv
rtl/int_execute.sv
rtl/procyon_core.sv
verif/tb_clk_gen.sv
verif/tb_procyon_core.sv

//--- rtl/core_control.sv
// One instruction in flight; the fetch state waits forever for i_ic_valid with no timeout
`timescale 1ns/1ps
`default_nettype none

module core_control (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_ic_valid,
    output logic o_ic_en,
    output logic o_capture,
    output logic o_decode,
    output logic o_execute
);

    // One flop per state
    logic idle_q;
    logic fetch_q;
    logic decode_q;
    logic execute_q;
    logic retire_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            idle_q    <= 1'b1;
            fetch_q   <= 1'b0;
            decode_q  <= 1'b0;
            execute_q <= 1'b0;
            retire_q  <= 1'b0;
        end else begin
            idle_q    <= 1'b0;
            fetch_q   <= idle_q | retire_q | (fetch_q & ~i_ic_valid);
            decode_q  <= fetch_q & i_ic_valid;
            execute_q <= decode_q;
            retire_q  <= execute_q;
        end
    end

    assign o_ic_en   = fetch_q;
    assign o_capture = fetch_q & i_ic_valid;
    assign o_decode  = decode_q;
    assign o_execute = execute_q;

    // Port stays idle through decode, execute and retire, then requests again
    a_ic_en_gap: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_capture |=> !o_ic_en [*3] ##1 o_ic_en)
        else $error("o_ic_en high while an instruction is in flight");

    a_onehot: assert property (@(posedge clk) disable iff (!i_rst_n)
        $onehot({idle_q, fetch_q, decode_q, execute_q, retire_q}))
        else $error("control state is not one-hot");

endmodule

`default_nettype wire

//--- rtl/exec_if.sv
// No valid flag; contents are live only while the control FSM is in its execute state
`timescale 1ns/1ps
`default_nettype none

interface exec_if;
    import procyon_pkg::*;

    logic [ALU_OP_WIDTH-1:0]  alu_op;
    logic [REG_IDX_WIDTH-1:0] rdest;
    logic [XLEN-1:0]          src_a;
    logic [XLEN-1:0]          src_b;
    logic [XLEN-1:0]          imm;
    logic [XLEN-1:0]          pc;

    modport decoder (
        output alu_op, rdest, src_a, src_b, imm, pc
    );

    modport execute (
        input  alu_op, rdest, src_a, src_b, imm, pc
    );

endinterface

`default_nettype wire

//--- rtl/fetch_unit.sv
// PC only moves on retire; o_ic_pc holds still for the whole fetch state
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_capture,
    input  logic [procyon_pkg::XLEN-1:0] i_ic_insn,
    retire_if.sink                    rt,
    output logic [procyon_pkg::XLEN-1:0] o_ic_pc,
    output logic [procyon_pkg::XLEN-1:0] o_insn,
    output logic [procyon_pkg::XLEN-1:0] o_pc
);
    import procyon_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] insn_q;
    logic [XLEN-1:0] insn_pc_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q <= RESET_PC;
        end else if (rt.en) begin
            pc_q <= rt.redirect ? rt.redirect_addr : pc_q + XLEN'(4);
        end
    end

    // Instruction word and its address
    always_ff @(posedge clk) begin
        if (i_capture) begin
            insn_q    <= i_ic_insn;
            insn_pc_q <= pc_q;
        end
    end

    assign o_ic_pc = pc_q;
    assign o_insn  = insn_q;
    assign o_pc    = insn_pc_q;

    // Captured address must not move under a retire
    a_pc_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_capture |-> !rt.en)
        else $error("retire during instruction capture");

endmodule

`default_nettype wire

//--- rtl/insn_decoder.sv
// Operands are read combinationally during decode; unsupported encodings become a no-op to x0
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
    input  logic                               clk,
    input  logic                               i_rst_n,
    input  logic                               i_decode,
    input  logic [procyon_pkg::XLEN-1:0]          i_insn,
    input  logic [procyon_pkg::XLEN-1:0]          i_pc,
    output logic [procyon_pkg::REG_IDX_WIDTH-1:0] o_rs1_idx,
    output logic [procyon_pkg::REG_IDX_WIDTH-1:0] o_rs2_idx,
    input  logic [procyon_pkg::XLEN-1:0]          i_rs1_data,
    input  logic [procyon_pkg::XLEN-1:0]          i_rs2_data,
    exec_if.decoder                            ex
);
    import procyon_pkg::*;

    insn_t                    w;
    logic [XLEN-1:0]          imm_i;
    logic [XLEN-1:0]          imm_b;
    logic [XLEN-1:0]          imm_u;
    logic [XLEN-1:0]          imm_j;
    logic [ALU_OP_WIDTH-1:0]  alu_op;
    logic [REG_IDX_WIDTH-1:0] rdest;
    logic [XLEN-1:0]          src_a;
    logic [XLEN-1:0]          src_b;
    logic [XLEN-1:0]          imm;

    // Bit 30 picks SUB only for register-register forms
    function automatic logic [ALU_OP_WIDTH-1:0] alu_map(input logic [2:0] funct3,
                                                        input logic       alt,
                                                        input logic       is_reg);
        case (funct3)
            3'b000:  return (alt && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign w     = i_insn;
    assign imm_i = {{20{w.i.imm[11]}}, w.i.imm};
    assign imm_b = {{20{w.b.imm12}}, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
    assign imm_u = {w.u.imm31_12, 12'b0};
    assign imm_j = {{12{w.j.imm20}}, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};

    assign o_rs1_idx = w.r.rs1;
    assign o_rs2_idx = w.r.rs2;

    always_comb begin
        alu_op = ALU_ADD;
        rdest  = '0;
        src_a  = '0;
        src_b  = '0;
        imm    = '0;
        case (w.r.opcode)
            OPC_OP: begin
                alu_op = alu_map(w.r.funct3, w.r.funct7[5], 1'b1);
                rdest  = w.r.rd;
                src_a  = i_rs1_data;
                src_b  = i_rs2_data;
            end
            OPC_OP_IMM: begin
                alu_op = alu_map(w.i.funct3, w.r.funct7[5], 1'b0);
                rdest  = w.i.rd;
                src_a  = i_rs1_data;
                src_b  = imm_i;
                imm    = imm_i;
            end
            OPC_LUI: begin
                rdest = w.u.rd;
                src_b = imm_u;
                imm   = imm_u;
            end
            OPC_AUIPC: begin
                rdest = w.u.rd;
                src_a = i_pc;
                src_b = imm_u;
                imm   = imm_u;
            end
            OPC_BRANCH: begin
                src_a = i_rs1_data;
                src_b = i_rs2_data;
                imm   = imm_b;
                case (w.b.funct3)
                    3'b000:  alu_op = ALU_BEQ;
                    3'b001:  alu_op = ALU_BNE;
                    3'b100:  alu_op = ALU_BLT;
                    3'b101:  alu_op = ALU_BGE;
                    default: begin
                        src_a = '0;
                        src_b = '0;
                    end
                endcase
            end
            OPC_JAL: begin
                alu_op = ALU_JAL;
                rdest  = w.j.rd;
                imm    = imm_j;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ex.alu_op <= ALU_ADD;
            ex.rdest  <= '0;
        end else if (i_decode) begin
            ex.alu_op <= alu_op;
            ex.rdest  <= rdest;
        end
    end

    always_ff @(posedge clk) begin
        if (i_decode) begin
            ex.src_a <= src_a;
            ex.src_b <= src_b;
            ex.imm   <= imm;
            ex.pc    <= i_pc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/int_execute.sv
// Retire fields hold for one cycle after each execute; only BEQ/BNE/BLT/BGE and JAL redirect
`timescale 1ns/1ps
`default_nettype none

module int_execute (
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_execute,
    exec_if.execute  ex,
    retire_if.source rt
);
    import procyon_pkg::*;

    logic [XLEN-1:0] result;
    logic [XLEN-1:0] target;
    logic            taken;
    logic            lt_s;
    logic            lt_u;
    logic [4:0]      shamt;

    assign lt_s   = $signed(ex.src_a) < $signed(ex.src_b);
    assign lt_u   = ex.src_a < ex.src_b;
    assign shamt  = ex.src_b[4:0];
    assign target = ex.pc + ex.imm;

    always_comb begin
        taken  = 1'b0;
        result = '0;
        case (ex.alu_op)
            ALU_ADD:  result = ex.src_a + ex.src_b;
            ALU_SUB:  result = ex.src_a - ex.src_b;
            ALU_AND:  result = ex.src_a & ex.src_b;
            ALU_OR:   result = ex.src_a | ex.src_b;
            ALU_XOR:  result = ex.src_a ^ ex.src_b;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_u};
            ALU_SLL:  result = ex.src_a << shamt;
            ALU_SRL:  result = ex.src_a >> shamt;
            ALU_SRA:  result = $unsigned($signed(ex.src_a) >>> shamt);
            ALU_BEQ:  taken = (ex.src_a == ex.src_b);
            ALU_BNE:  taken = (ex.src_a != ex.src_b);
            ALU_BLT:  taken = lt_s;
            ALU_BGE:  taken = !lt_s;
            ALU_JAL: begin
                taken  = 1'b1;
                result = ex.pc + XLEN'(4);
            end
            default:  result = '0;
        endcase
        // Branches report the decision as data
        if (ex.alu_op inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE}) begin
            result = {{(XLEN-1){1'b0}}, taken};
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rt.en       <= 1'b0;
            rt.redirect <= 1'b0;
        end else begin
            rt.en       <= i_execute;
            rt.redirect <= i_execute & taken;
        end
    end

    always_ff @(posedge clk) begin
        if (i_execute) begin
            rt.rdest         <= ex.rdest;
            rt.data          <= result;
            rt.redirect_addr <= target;
        end
    end

    // Holds only while the fetched PC stays halfword aligned
    a_target_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
        rt.redirect |-> !rt.redirect_addr[0])
        else $error("redirect to odd address");

endmodule

`default_nettype wire

//--- rtl/procyon_core.sv
// In-order RV32I subset; retire and redirect outputs are debug views of the retire stage
`timescale 1ns/1ps
`default_nettype none

module procyon_core (
    input  logic                               clk,
    input  logic                               i_rst_n,
    input  logic [procyon_pkg::XLEN-1:0]          i_ic_insn,
    input  logic                               i_ic_valid,
    output logic [procyon_pkg::XLEN-1:0]          o_ic_pc,
    output logic                               o_ic_en,
    output logic                               o_redirect,
    output logic [procyon_pkg::XLEN-1:0]          o_redirect_addr,
    output logic                               o_retire_en,
    output logic [procyon_pkg::REG_IDX_WIDTH-1:0] o_retire_rdest,
    output logic [procyon_pkg::XLEN-1:0]          o_retire_data
);
    import procyon_pkg::*;

    logic                     capture;
    logic                     decode;
    logic                     execute;
    logic [XLEN-1:0]          insn;
    logic [XLEN-1:0]          insn_pc;
    logic [REG_IDX_WIDTH-1:0] rs1_idx;
    logic [REG_IDX_WIDTH-1:0] rs2_idx;
    logic [XLEN-1:0]          rs1_data;
    logic [XLEN-1:0]          rs2_data;

    exec_if   ex_bus ();
    retire_if rt_bus ();

    assign o_retire_en     = rt_bus.en;
    assign o_retire_rdest  = rt_bus.rdest;
    assign o_retire_data   = rt_bus.data;
    assign o_redirect      = rt_bus.redirect;
    assign o_redirect_addr = rt_bus.redirect_addr;

    core_control control_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_ic_valid(i_ic_valid),
        .o_ic_en(o_ic_en),
        .o_capture(capture),
        .o_decode(decode),
        .o_execute(execute)
    );

    fetch_unit fetch_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_capture(capture),
        .i_ic_insn(i_ic_insn),
        .rt(rt_bus.sink),
        .o_ic_pc(o_ic_pc),
        .o_insn(insn),
        .o_pc(insn_pc)
    );

    insn_decoder decode_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_decode(decode),
        .i_insn(insn),
        .i_pc(insn_pc),
        .o_rs1_idx(rs1_idx),
        .o_rs2_idx(rs2_idx),
        .i_rs1_data(rs1_data),
        .i_rs2_data(rs2_data),
        .ex(ex_bus.decoder)
    );

    register_file regfile_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_rs1_idx(rs1_idx),
        .i_rs2_idx(rs2_idx),
        .o_rs1_data(rs1_data),
        .o_rs2_data(rs2_data),
        .rt(rt_bus.sink)
    );

    int_execute execute_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_execute(execute),
        .ex(ex_bus.execute),
        .rt(rt_bus.source)
    );

endmodule

`default_nettype wire

//--- rtl/procyon_pkg.sv
// RV32I subset only; no loads, stores, CSRs or BLTU/BGEU, and RESET_PC must be word aligned
`default_nettype none

package procyon_pkg;

    localparam int XLEN          = 32;
    localparam int REG_COUNT     = 32;
    localparam int REG_IDX_WIDTH = $clog2(REG_COUNT);
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam int ALU_OP_WIDTH = 4;

    localparam logic [ALU_OP_WIDTH-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_AND  = 4'd2;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_OR   = 4'd3;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SLT  = 4'd5;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SLTU = 4'd6;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SLL  = 4'd7;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SRL  = 4'd8;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SRA  = 4'd9;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_BEQ  = 4'd10;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_BNE  = 4'd11;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_BLT  = 4'd12;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_BGE  = 4'd13;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_JAL  = 4'd14;

    // One instruction word, five field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } insn_t;

endpackage

`default_nettype wire

//--- rtl/register_file.sv
// Contents are undefined after reset except x0; reads are combinational
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                               clk,
    input  logic                               i_rst_n,
    input  logic [procyon_pkg::REG_IDX_WIDTH-1:0] i_rs1_idx,
    input  logic [procyon_pkg::REG_IDX_WIDTH-1:0] i_rs2_idx,
    output logic [procyon_pkg::XLEN-1:0]          o_rs1_data,
    output logic [procyon_pkg::XLEN-1:0]          o_rs2_data,
    retire_if.sink                             rt
);
    import procyon_pkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];

    // x0 may be written but is never read back
    always_ff @(posedge clk) begin
        if (rt.en) begin
            regs[rt.rdest] <= rt.data;
        end
    end

    assign o_rs1_data = (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
    assign o_rs2_data = (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];

    a_rdest_known: assert property (@(posedge clk) disable iff (!i_rst_n)
        rt.en |-> !$isunknown(rt.rdest))
        else $error("retire with unknown rdest");

endmodule

`default_nettype wire

//--- rtl/retire_if.sv
// en and redirect are single-cycle pulses; the other fields are only meaningful while en is high
`timescale 1ns/1ps
`default_nettype none

interface retire_if;
    import procyon_pkg::*;

    logic                     en;
    logic [REG_IDX_WIDTH-1:0] rdest;
    logic [XLEN-1:0]          data;
    logic                     redirect;
    logic [XLEN-1:0]          redirect_addr;

    modport source (
        output en, rdest, data, redirect, redirect_addr
    );

    modport sink (
        input  en, rdest, data, redirect, redirect_addr
    );

endinterface

`default_nettype wire

//--- verif/tb_clk_gen.sv
// 10 ns clock from time 0; reset is low for the first 10 rising edges, then released on an edge
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (10) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/tb_procyon_core.sv
// Program memory holds 1024 words indexed by PC bits 11:2; outputs are sampled on falling edges
`timescale 1ns/1ps
`default_nettype none

module tb_procyon_core;
    import procyon_pkg::*;

    localparam int WAIT_LIMIT = 100;

    logic                     clk;
    logic                     rst_n;
    logic [XLEN-1:0]          i_ic_insn;
    logic                     i_ic_valid;
    logic [XLEN-1:0]          o_ic_pc;
    logic                     o_ic_en;
    logic                     o_redirect;
    logic [XLEN-1:0]          o_redirect_addr;
    logic                     o_retire_en;
    logic [REG_IDX_WIDTH-1:0] o_retire_rdest;
    logic [XLEN-1:0]          o_retire_data;

    logic [31:0] prog [1024];
    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;
    logic [31:0] lfsr;
    int          n_checks;
    int          n_errors;
    int          n_timeouts;

    tb_clk_gen u_clk (
        .o_clk(clk),
        .o_rst_n(rst_n)
    );

    procyon_core u_dut (
        .clk(clk),
        .i_rst_n(rst_n),
        .i_ic_insn(i_ic_insn),
        .i_ic_valid(i_ic_valid),
        .o_ic_pc(o_ic_pc),
        .o_ic_en(o_ic_en),
        .o_redirect(o_redirect),
        .o_redirect_addr(o_redirect_addr),
        .o_retire_en(o_retire_en),
        .o_retire_rdest(o_retire_rdest),
        .o_retire_data(o_retire_data)
    );

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Word-aligned offset in -128..124
    function automatic logic [31:0] rand_offset();
        logic [31:0] r;
        logic [7:0]  o;
        r = rand_bits(6);
        o = {r[5:0], 2'b00};
        return {{24{o[7]}}, o};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm[11:0], rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [31:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm[19:0], rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAIL t=%0t %s got=%h expected=%h", $time, name, actual, expected);
        end
    endtask

    task automatic note_timeout(input string what);
        n_timeouts++;
        $display("ERROR t=%0t timed out waiting for %s", $time, what);
    endtask

    // Reference model of the retire rules
    task automatic predict(input logic [31:0] insn, output logic [4:0] rd,
                           output logic [31:0] data, output logic redir,
                           output logic [31:0] addr);
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic        alt;
        logic        taken;
        f3    = insn[14:12];
        alt   = insn[30];
        a     = ref_regs[insn[19:15]];
        b     = (insn[6:0] == OPC_OP_IMM) ? {{20{insn[31]}}, insn[31:20]} : ref_regs[insn[24:20]];
        rd    = '0;
        data  = '0;
        redir = 1'b0;
        addr  = '0;
        taken = 1'b0;
        case (insn[6:0])
            OPC_OP, OPC_OP_IMM: begin
                rd = insn[11:7];
                case (f3)
                    3'd0: data = (alt && insn[6:0] == OPC_OP) ? a - b : a + b;
                    3'd1: data = a << b[4:0];
                    3'd2: data = {31'b0, $signed(a) < $signed(b)};
                    3'd3: data = {31'b0, a < b};
                    3'd4: data = a ^ b;
                    3'd5: data = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'd6: data = a | b;
                    default: data = a & b;
                endcase
            end
            OPC_LUI: begin
                rd   = insn[11:7];
                data = {insn[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                rd   = insn[11:7];
                data = ref_pc + {insn[31:12], 12'b0};
            end
            OPC_BRANCH: begin
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    default: taken = 1'b0;
                endcase
                data  = {31'b0, taken};
                redir = taken;
                addr  = ref_pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
            end
            OPC_JAL: begin
                rd    = insn[11:7];
                data  = ref_pc + 32'd4;
                redir = 1'b1;
                addr  = ref_pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
            end
            default: ;
        endcase
    endtask

    // Places one instruction at the reference PC, serves it and checks its retire
    task automatic run_insn(input logic [31:0] insn);
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        logic        exp_redir;
        logic [31:0] exp_addr;
        logic [31:0] word;
        int          cycles;
        int          delay;
        logic        seen;
        prog[ref_pc[11:2]] = insn;
        predict(insn, exp_rd, exp_data, exp_redir, exp_addr);
        delay  = int'(rand_bits(2));
        cycles = 0;
        while (o_ic_en !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (o_ic_en !== 1'b1) begin
            note_timeout("o_ic_en");
            return;
        end
        check_value("o_ic_pc", o_ic_pc, ref_pc);
        word = prog[o_ic_pc[11:2]];
        repeat (delay) @(posedge clk);
        @(posedge clk);
        i_ic_valid <= 1'b1;
        i_ic_insn  <= word;
        // Sampling edge; the bus is scrambled right after it
        @(posedge clk);
        i_ic_valid <= 1'b0;
        i_ic_insn  <= ~word;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (o_retire_en === 1'b1) begin
                seen = 1'b1;
            end else begin
                check_value("o_ic_en", o_ic_en, 0);
                check_value("o_redirect", o_redirect, 0);
            end
        end
        if (!seen) begin
            note_timeout("o_retire_en");
            return;
        end
        check_value("retire cycle", cycles, 3);
        check_value("o_ic_en", o_ic_en, 0);
        check_value("o_retire_rdest", o_retire_rdest, exp_rd);
        check_value("o_retire_data", o_retire_data, exp_data);
        check_value("o_redirect", o_redirect, exp_redir);
        if (exp_redir) begin
            check_value("o_redirect_addr", o_redirect_addr, exp_addr);
        end
        @(negedge clk);
        check_value("o_retire_en", o_retire_en, 0);
        check_value("o_redirect", o_redirect, 0);
        check_value("o_ic_en", o_ic_en, 1);
        if (exp_rd != 5'd0) begin
            ref_regs[exp_rd] = exp_data;
        end
        ref_pc = exp_redir ? exp_addr : ref_pc + 32'd4;
    endtask

    task automatic test_reset();
        int cycles;
        @(posedge clk);
        @(negedge clk);
        check_value("o_ic_en", o_ic_en, 0);
        check_value("o_retire_en", o_retire_en, 0);
        check_value("o_redirect", o_redirect, 0);
        check_value("o_ic_pc", o_ic_pc, RESET_PC);
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        check_value("o_ic_en", o_ic_en, 0);
        cycles = 0;
        while (o_ic_en !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            check_value("o_retire_en", o_retire_en, 0);
        end
        check_value("cycles to o_ic_en", cycles, 1);
        check_value("o_ic_pc", o_ic_pc, RESET_PC);
    endtask

    task automatic test_alu_ops();
        logic [31:0] imm;
        logic [31:0] sh;
        run_insn(enc_i(rand_bits(12), 5'd0, 3'd0, 5'd1));
        run_insn(enc_i(rand_bits(12), 5'd0, 3'd0, 5'd2));
        run_insn(enc_u(rand_bits(20), 5'd3, OPC_LUI));
        run_insn(enc_i(rand_bits(12), 5'd3, 3'd0, 5'd3));
        run_insn(enc_u(rand_bits(20), 5'd4, OPC_AUIPC));
        for (int f3 = 0; f3 < 8; f3++) begin
            run_insn(enc_r(7'h00, 5'd2, 5'd1, 3'(f3), 5'(10 + f3)));
        end
        run_insn(enc_r(7'h20, 5'd3, 5'd1, 3'd0, 5'd20));
        run_insn(enc_r(7'h20, 5'd2, 5'd3, 3'd5, 5'd21));
        // Immediate forms read back the register results
        for (int f3 = 0; f3 < 8; f3++) begin
            sh  = rand_bits(5);
            imm = (f3 == 1 || f3 == 5) ? {20'b0, 7'h00, sh[4:0]} : rand_bits(12);
            run_insn(enc_i(imm, 5'(10 + f3), 3'(f3), 5'(22 + f3)));
        end
        sh = rand_bits(5);
        run_insn(enc_i({20'b0, 7'h20, sh[4:0]}, 5'd3, 3'd5, 5'd30));
        run_insn(enc_r(7'h00, 5'd29, 5'd22, 3'd0, 5'd31));
    endtask

    task automatic test_x0_writes();
        run_insn(enc_i(rand_bits(12), 5'd1, 3'd0, 5'd0));
        run_insn(enc_u(rand_bits(20), 5'd0, OPC_LUI));
        run_insn(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd5));
        run_insn(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd6));
    endtask

    task automatic test_branches();
        logic [2:0] f3;
        run_insn(enc_i(rand_bits(12), 5'd0, 3'd0, 5'd8));
        run_insn(enc_i(32'd0, 5'd8, 3'd0, 5'd9));
        run_insn(enc_i(32'd1, 5'd8, 3'd0, 5'd10));
        for (int i = 0; i < 4; i++) begin
            f3 = (i < 2) ? 3'(i) : 3'(i + 2);
            run_insn(enc_b(rand_offset(), 5'd9, 5'd8, f3));
            run_insn(enc_b(rand_offset(), 5'd10, 5'd8, f3));
            run_insn(enc_b(rand_offset(), 5'd8, 5'd10, f3));
        end
    endtask

    task automatic test_jal();
        logic [31:0] r;
        logic [4:0]  rd;
        for (int i = 0; i < 4; i++) begin
            r  = rand_bits(4);
            rd = (i == 0) ? 5'd0 : {r[3:0], 1'b1};
            run_insn(enc_j(rand_offset(), rd));
            run_insn(enc_r(7'h00, 5'd0, rd, 3'd0, 5'd7));
        end
    endtask

    initial begin
        i_ic_valid = 1'b0;
        i_ic_insn  = '0;
        lfsr       = 32'h2f67;
        ref_pc     = RESET_PC;
        n_checks   = 0;
        n_errors   = 0;
        n_timeouts = 0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        test_reset();
        test_alu_ops();
        test_x0_writes();
        test_branches();
        test_jal();
        $display("checks=%0d errors=%0d timeouts=%0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
